// ==== bench/execUnit_checker.sv ====
`timescale 1ns/1ps

module execUnit_checker (
    input logic       clk,
    input logic       arstN,
    input logic       instrValid,
    input logic       resultValid,
    input logic       branchTaken,
    input logic       illegalOut,
    input logic [4:0] rdIndex
);

    // Nothing retires right after reset release unless an instruction came in
    idleAfterReset: assert property (
        @(posedge clk) $rose(arstN) && !instrValid |=> !resultValid
    ) else $error("resultValid set after reset release with no instruction accepted");

    takenNeedsValid: assert property (
        @(posedge clk) disable iff (!arstN) branchTaken |-> resultValid
    ) else $error("branchTaken set without resultValid");

    // Illegal instructions name no destination
    illegalNoDest: assert property (
        @(posedge clk) disable iff (!arstN) illegalOut |-> (rdIndex == 5'd0)
    ) else $error("illegalOut set with a non-zero rdIndex");

    validOneCycle: assert property (
        @(posedge clk) disable iff (!arstN) resultValid == $past(instrValid)
    ) else $error("resultValid does not follow instrValid by one cycle");

endmodule

// ==== bench/execUnit_tb.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module execUnit_tb;

    localparam int NumTests = 34;
    // Table length plus reset, drain and slack
    localparam int CycleLimit = NumTests + 20;

    logic                  clk = 1'b0;
    logic                  arstN = 1'b0;
    logic                  instrValid = 1'b0;
    logic [`EXEC_XLEN-1:0] instr = '0;
    logic [`EXEC_XLEN-1:0] pc = '0;
    logic                  resultValid;
    logic [4:0]            rdIndex;
    logic [`EXEC_XLEN-1:0] rdValue;
    logic                  branchTaken;
    logic [`EXEC_XLEN-1:0] branchTarget;
    logic                  illegalOut;

    // Stimulus and expected results, one slot per test
    string                 names [NumTests];
    logic [`EXEC_XLEN-1:0] pcs [NumTests];
    logic [`EXEC_XLEN-1:0] instrs [NumTests];
    logic [4:0]            expRd [NumTests];
    logic [`EXEC_XLEN-1:0] expValue [NumTests];
    logic                  expTaken [NumTests];
    logic [`EXEC_XLEN-1:0] expTarget [NumTests];
    logic                  expIllegal [NumTests];

    int numLoaded = 0;
    int passCount = 0;
    int failCount = 0;
    int cycles = 0;

    execUnit u_execUnit (
        .clk          (clk),
        .arstN        (arstN),
        .instrValid   (instrValid),
        .instr        (instr),
        .pc           (pc),
        .resultValid  (resultValid),
        .rdIndex      (rdIndex),
        .rdValue      (rdValue),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .illegalOut   (illegalOut)
    );

    bind execUnit execUnit_checker u_execUnitChecker (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .resultValid (resultValid),
        .branchTaken (branchTaken),
        .illegalOut  (illegalOut),
        .rdIndex     (rdIndex)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("Timeout after %0d cycles, the test loop never finished", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // Instruction encoders
    function automatic logic [31:0] rType(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input int imm, input int rs1, input int f3,
                                          input int rd);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] uType(input int imm, input int rd, input int opc);
        return {20'(imm), 5'(rd), 7'(opc)};
    endfunction

    function automatic logic [31:0] bType(input int off, input int rs2, input int rs1,
                                          input int f3);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'b1100011};
    endfunction

    task automatic addTest(input string name, input int pcVal, input logic [31:0] word,
                           input int rd, input int value, input int taken,
                           input int target, input int ill);
        names[numLoaded]      = name;
        pcs[numLoaded]        = 32'(pcVal);
        instrs[numLoaded]     = word;
        expRd[numLoaded]      = 5'(rd);
        expValue[numLoaded]   = 32'(value);
        expTaken[numLoaded]   = taken != 0;
        expTarget[numLoaded]  = 32'(target);
        expIllegal[numLoaded] = ill != 0;
        numLoaded++;
    endtask

    task automatic loadTable();
        addTest("addi x1 100", 'h1000, iType(100, 0, 0, 1), 1, 'h64, 0, 0, 0);
        addTest("addi x2 -7", 'h1004, iType(-7, 0, 0, 2), 2, 'hFFFFFFF9, 0, 0, 0);
        addTest("add", 'h1008, rType(0, 2, 1, 0, 3), 3, 'h5D, 0, 0, 0);
        addTest("sub wrap", 'h100C, rType('h20, 1, 2, 0, 4), 4, 'hFFFFFF95, 0, 0, 0);
        addTest("xor", 'h1010, rType(0, 2, 1, 4, 5), 5, 'hFFFFFF9D, 0, 0, 0);
        addTest("or", 'h1014, rType(0, 2, 1, 6, 6), 6, 'hFFFFFFFD, 0, 0, 0);
        addTest("and", 'h1018, rType(0, 2, 1, 7, 7), 7, 'h60, 0, 0, 0);
        addTest("slli 4", 'h101C, iType(4, 2, 1, 8), 8, 'hFFFFFF90, 0, 0, 0);
        addTest("srli 1", 'h1020, iType(1, 2, 5, 9), 9, 'h7FFFFFFC, 0, 0, 0);
        addTest("srai 1", 'h1024, iType('h401, 2, 5, 10), 10, 'hFFFFFFFC, 0, 0, 0);
        addTest("addi x11 33", 'h1028, iType(33, 0, 0, 11), 11, 'h21, 0, 0, 0);
        // Shift by 33 acts as shift by 1
        addTest("sll by 33", 'h102C, rType(0, 11, 1, 1, 12), 12, 'hC8, 0, 0, 0);
        addTest("addi x14 -1", 'h1030, iType(-1, 0, 0, 14), 14, 'hFFFFFFFF, 0, 0, 0);
        addTest("addi x15 1", 'h1034, iType(1, 0, 0, 15), 15, 'h1, 0, 0, 0);
        addTest("slt -1 1", 'h1038, rType(0, 15, 14, 2, 16), 16, 'h1, 0, 0, 0);
        addTest("sltu -1 1", 'h103C, rType(0, 15, 14, 3, 17), 17, 'h0, 0, 0, 0);
        addTest("beq taken", 'h1040, bType(8, 1, 1, 0), 0, 0, 1, 'h1048, 0);
        addTest("beq not taken", 'h1044, bType(8, 2, 1, 0), 0, 0, 0, 'h104C, 0);
        addTest("bne taken", 'h1048, bType(12, 2, 1, 1), 0, 0, 1, 'h1054, 0);
        addTest("blt taken", 'h104C, bType(16, 15, 14, 4), 0, 0, 1, 'h105C, 0);
        addTest("bge not taken", 'h1050, bType(16, 15, 14, 5), 0, 0, 0, 'h1060, 0);
        addTest("bge taken", 'h1054, bType(20, 14, 15, 5), 0, 0, 1, 'h1068, 0);
        addTest("bltu not taken", 'h1058, bType(8, 15, 14, 6), 0, 0, 0, 'h1060, 0);
        addTest("bltu back", 'h105C, bType(-8, 14, 15, 6), 0, 0, 1, 'h1054, 0);
        addTest("bgeu back", 'h1060, bType(-16, 15, 14, 7), 0, 0, 1, 'h1050, 0);
        addTest("bne not taken", 'h1064, bType(8, 1, 1, 1), 0, 0, 0, 'h106C, 0);
        addTest("blt not taken", 'h1068, bType(12, 14, 15, 4), 0, 0, 0, 'h1074, 0);
        addTest("bgeu not taken", 'h106C, bType(-12, 14, 15, 7), 0, 0, 0, 'h1060, 0);
        addTest("lui", 'h1070, uType('h12345, 18, 'h37), 18, 'h12345000, 0, 0, 0);
        addTest("auipc", 'h1074, uType(1, 19, 'h17), 19, 'h2074, 0, 0, 0);
        addTest("lui x0", 'h1078, uType('hABCDE, 0, 'h37), 0, 'hABCDE000, 0, 0, 0);
        addTest("x0 reads zero", 'h107C, rType(0, 0, 18, 0, 20), 20, 'h12345000, 0, 0, 0);
        // lw x1, 0(x0) is outside the supported set
        addTest("illegal load", 'h1080, 'h00002083, 0, 0, 0, 0, 1);
        addTest("x1 kept", 'h1084, rType(0, 0, 1, 0, 21), 21, 'h64, 0, 0, 0);
    endtask

    task automatic checkResult(input int i);
        bit ok;
        ok = 1'b1;
        assert (resultValid) else begin
            $display("%s: resultValid did not pulse one cycle after the instruction", names[i]);
            ok = 1'b0;
        end
        assert (rdIndex == expRd[i]) else begin
            $display("FAILED %s rdIndex expected %0d actual %0d", names[i], expRd[i], rdIndex);
            ok = 1'b0;
        end
        assert (rdValue == expValue[i]) else begin
            $display("FAILED %s rdValue expected %h actual %h", names[i], expValue[i], rdValue);
            ok = 1'b0;
        end
        assert (branchTaken == expTaken[i]) else begin
            $display("FAILED %s branchTaken expected %0b actual %0b",
                     names[i], expTaken[i], branchTaken);
            ok = 1'b0;
        end
        assert (branchTarget == expTarget[i]) else begin
            $display("FAILED %s branchTarget expected %h actual %h",
                     names[i], expTarget[i], branchTarget);
            ok = 1'b0;
        end
        assert (illegalOut == expIllegal[i]) else begin
            $display("FAILED %s illegalOut expected %0b actual %0b",
                     names[i], expIllegal[i], illegalOut);
            ok = 1'b0;
        end
        if (ok) begin
            passCount++;
            $display("passed %s", names[i]);
        end else begin
            failCount++;
        end
    endtask

    initial begin
        loadTable();
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        // Drive entry i, then check entry i-1 which retired at that edge
        for (int i = 0; i <= NumTests; i++) begin
            @(posedge clk);
            if (i < NumTests) begin
                instrValid <= 1'b1;
                instr      <= instrs[i];
                pc         <= pcs[i];
            end else begin
                instrValid <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                checkResult(i - 1);
            end
        end
        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== design/aluCore.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module aluCore (
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    input  execPkg::aluOpT        aluOp,
    output logic [`EXEC_XLEN-1:0] result
);

    logic [`EXEC_SHAMT_W-1:0] shamt;
    logic                     ltSigned;
    logic                     ltUnsigned;

    // Only the low bits of b count as shift amount
    assign shamt      = b[`EXEC_SHAMT_W-1:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (aluOp)
            execPkg::aluAdd:  result = a + b;
            execPkg::aluSub:  result = a - b;
            execPkg::aluSll:  result = a << shamt;
            execPkg::aluSlt:  result = {{(`EXEC_XLEN-1){1'b0}}, ltSigned};
            execPkg::aluSltu: result = {{(`EXEC_XLEN-1){1'b0}}, ltUnsigned};
            execPkg::aluXor:  result = a ^ b;
            execPkg::aluSrl:  result = a >> shamt;
            // Sign bit fills from the left
            execPkg::aluSra:  result = $unsigned($signed(a) >>> shamt);
            execPkg::aluOr:   result = a | b;
            execPkg::aluAnd:  result = a & b;
            default:          result = '0;
        endcase
    end

endmodule

// ==== design/branchUnit.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module branchUnit (
    input  logic [`EXEC_XLEN-1:0] rs1Val,
    input  logic [`EXEC_XLEN-1:0] rs2Val,
    input  logic [`EXEC_XLEN-1:0] pc,
    input  logic [`EXEC_XLEN-1:0] imm,
    input  rvIsaPkg::funct3T      funct3,
    output logic                  taken,
    output logic [`EXEC_XLEN-1:0] target
);

    logic isEq;
    logic isLt;
    logic isLtu;

    assign isEq  = rs1Val == rs2Val;
    assign isLt  = $signed(rs1Val) < $signed(rs2Val);
    assign isLtu = rs1Val < rs2Val;

    always_comb begin
        case (funct3)
            rvIsaPkg::f3Beq:  taken = isEq;
            rvIsaPkg::f3Bne:  taken = !isEq;
            rvIsaPkg::f3Blt:  taken = isLt;
            rvIsaPkg::f3Bge:  taken = !isLt;
            rvIsaPkg::f3Bltu: taken = isLtu;
            rvIsaPkg::f3Bgeu: taken = !isLtu;
            default:          taken = 1'b0;
        endcase
    end

    // Offset is already sign extended
    assign target = pc + imm;

endmodule

// ==== design/execControl.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module execControl (
    input  logic                   instrValid,
    input  logic [`EXEC_XLEN-1:0]  instr,
    output execPkg::aluOpT         aluOp,
    output execPkg::immKindT       immKind,
    output execPkg::srcAT          srcA,
    output logic                   srcBImm,
    output logic                   isBranch,
    output logic                   writeEn,
    output logic                   illegal
);

    rvIsaPkg::opcodeT opcode;
    rvIsaPkg::funct3T funct3;
    logic [6:0]       funct7;
    logic             bad;

    assign opcode = rvIsaPkg::opcodeT'(instr[6:0]);
    assign funct3 = instr[14:12];
    // funct7 sits right above the shift amount field
    assign funct7 = instr[`EXEC_XLEN-1:20+`EXEC_SHAMT_W];

    always_comb begin
        aluOp    = execPkg::aluAdd;
        immKind  = execPkg::immI;
        srcA     = execPkg::srcReg;
        srcBImm  = 1'b0;
        isBranch = 1'b0;
        bad      = 1'b0;
        case (opcode)
            rvIsaPkg::opcOp: begin
                aluOp = execPkg::aluOpT'({funct7[5], funct3});
                // Only ADD/SUB and SRL/SRA accept the alternate funct7
                if (funct7 == 7'h20) begin
                    bad = (funct3 != rvIsaPkg::f3AddSub) && (funct3 != rvIsaPkg::f3SrlSra);
                end else begin
                    bad = (funct7 != 7'h00);
                end
            end
            rvIsaPkg::opcOpImm: begin
                srcBImm = 1'b1;
                if (funct3 == rvIsaPkg::f3SrlSra) begin
                    aluOp = execPkg::aluOpT'({funct7[5], funct3});
                    bad   = (funct7 != 7'h00) && (funct7 != 7'h20);
                end else if (funct3 == rvIsaPkg::f3Sll) begin
                    aluOp = execPkg::aluSll;
                    bad   = (funct7 != 7'h00);
                end else begin
                    // No SUBI, upper bits are immediate
                    aluOp = execPkg::aluOpT'({1'b0, funct3});
                end
            end
            rvIsaPkg::opcLui: begin
                srcA    = execPkg::srcZero;
                srcBImm = 1'b1;
                immKind = execPkg::immU;
            end
            rvIsaPkg::opcAuipc: begin
                srcA    = execPkg::srcPc;
                srcBImm = 1'b1;
                immKind = execPkg::immU;
            end
            rvIsaPkg::opcBranch: begin
                isBranch = 1'b1;
                immKind  = execPkg::immB;
                // funct3 010 and 011 are not defined for branches
                bad = (funct3 == rvIsaPkg::f3Slt) || (funct3 == rvIsaPkg::f3Sltu);
            end
            default: begin
                bad = 1'b1;
            end
        endcase
    end

    assign illegal = bad;
    assign writeEn = instrValid && !bad && !isBranch;

endmodule

// ==== design/execPkg.sv ====
package execPkg;

    // ALU operation, funct7[5] on top of funct3
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSll  = 4'b0001,
        aluSlt  = 4'b0010,
        aluSltu = 4'b0011,
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111,
        aluSub  = 4'b1000,
        aluSra  = 4'b1101
    } aluOpT;

    // Immediate layouts
    typedef enum logic [1:0] {
        immI = 2'd0,
        immU = 2'd1,
        immB = 2'd2
    } immKindT;

    // Operand A source
    typedef enum logic [1:0] {
        srcReg  = 2'd0,
        srcPc   = 2'd1,
        srcZero = 2'd2
    } srcAT;

endpackage

// ==== design/execUnit.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module execUnit (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  instrValid,
    input  logic [`EXEC_XLEN-1:0] instr,
    input  logic [`EXEC_XLEN-1:0] pc,
    output logic                  resultValid,
    output logic [4:0]            rdIndex,
    output logic [`EXEC_XLEN-1:0] rdValue,
    output logic                  branchTaken,
    output logic [`EXEC_XLEN-1:0] branchTarget,
    output logic                  illegalOut
);

    execPkg::aluOpT        aluOp;
    execPkg::immKindT      immKind;
    execPkg::srcAT         srcA;
    logic                  srcBImm;
    logic                  isBranch;
    logic                  writeEn;
    logic                  illegal;
    logic [`EXEC_XLEN-1:0] imm;
    logic [`EXEC_XLEN-1:0] rs1Val;
    logic [`EXEC_XLEN-1:0] rs2Val;
    logic [`EXEC_XLEN-1:0] opA;
    logic [`EXEC_XLEN-1:0] opB;
    logic [`EXEC_XLEN-1:0] aluResult;
    logic                  brTaken;
    logic [`EXEC_XLEN-1:0] brTarget;

    execControl u_execControl (
        .instrValid (instrValid),
        .instr      (instr),
        .aluOp      (aluOp),
        .immKind    (immKind),
        .srcA       (srcA),
        .srcBImm    (srcBImm),
        .isBranch   (isBranch),
        .writeEn    (writeEn),
        .illegal    (illegal)
    );

    immGen u_immGen (
        .instr   (instr),
        .immKind (immKind),
        .imm     (imm)
    );

    regFile u_regFile (
        .clk     (clk),
        .arstN   (arstN),
        .rs1Idx  (instr[19:15]),
        .rs2Idx  (instr[24:20]),
        .rdIdx   (instr[11:7]),
        .writeEn (writeEn),
        .rdData  (aluResult),
        .rs1Val  (rs1Val),
        .rs2Val  (rs2Val)
    );

    // Operand muxes
    always_comb begin
        case (srcA)
            execPkg::srcPc:   opA = pc;
            execPkg::srcZero: opA = '0;
            default:          opA = rs1Val;
        endcase
    end

    assign opB = srcBImm ? imm : rs2Val;

    aluCore u_aluCore (
        .a      (opA),
        .b      (opB),
        .aluOp  (aluOp),
        .result (aluResult)
    );

    branchUnit u_branchUnit (
        .rs1Val (rs1Val),
        .rs2Val (rs2Val),
        .pc     (pc),
        .imm    (imm),
        .funct3 (instr[14:12]),
        .taken  (brTaken),
        .target (brTarget)
    );

    // Retire stage, one cycle after acceptance
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultValid  <= 1'b0;
            branchTaken  <= 1'b0;
            illegalOut   <= 1'b0;
            rdIndex      <= '0;
            rdValue      <= '0;
            branchTarget <= '0;
        end else begin
            resultValid <= instrValid;
            branchTaken <= instrValid && isBranch && !illegal && brTaken;
            illegalOut  <= instrValid && illegal;
            if (instrValid) begin
                // Branches and illegal opcodes report no destination
                rdIndex      <= writeEn ? instr[11:7] : 5'd0;
                rdValue      <= writeEn ? aluResult : '0;
                branchTarget <= isBranch ? brTarget : '0;
            end
        end
    end

endmodule

// ==== design/exec_cfg.svh ====
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Data and address width
`define EXEC_XLEN 32

// Architectural register count
`define EXEC_REGS 32

// Shift amount field width
`define EXEC_SHAMT_W 5

`endif

// ==== design/immGen.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module immGen (
    input  logic [`EXEC_XLEN-1:0] instr,
    input  execPkg::immKindT      immKind,
    output logic [`EXEC_XLEN-1:0] imm
);

    logic [`EXEC_XLEN-1:0] immIVal;
    logic [`EXEC_XLEN-1:0] immUVal;
    logic [`EXEC_XLEN-1:0] immBVal;

    // 12-bit signed, bits 31:20
    assign immIVal = {{(`EXEC_XLEN-12){instr[31]}}, instr[31:20]};

    // Upper 20 bits, low 12 zero
    assign immUVal = {instr[31:12], 12'b0};

    // 13-bit signed offset, always even
    assign immBVal = {{(`EXEC_XLEN-13){instr[31]}}, instr[31], instr[7],
                      instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        case (immKind)
            execPkg::immU: imm = immUVal;
            execPkg::immB: imm = immBVal;
            default:       imm = immIVal;
        endcase
    end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module regFile (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [4:0]            rs1Idx,
    input  logic [4:0]            rs2Idx,
    input  logic [4:0]            rdIdx,
    input  logic                  writeEn,
    input  logic [`EXEC_XLEN-1:0] rdData,
    output logic [`EXEC_XLEN-1:0] rs1Val,
    output logic [`EXEC_XLEN-1:0] rs2Val
);

    logic [`EXEC_XLEN-1:0] regs [`EXEC_REGS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `EXEC_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (rdIdx != 5'd0)) begin
            // x0 never leaves its reset value
            regs[rdIdx] <= rdData;
        end
    end

    // Combinational reads see a write one edge after it lands
    assign rs1Val = regs[rs1Idx];
    assign rs2Val = regs[rs2Idx];

endmodule

// ==== design/rvIsaPkg.sv ====
package rvIsaPkg;

    // Major opcodes handled by the execute unit
    typedef enum logic [6:0] {
        opcOp     = 7'b0110011,
        opcOpImm  = 7'b0010011,
        opcLui    = 7'b0110111,
        opcAuipc  = 7'b0010111,
        opcBranch = 7'b1100011
    } opcodeT;

    // Arithmetic and branch codes share values, so plain named constants
    typedef logic [2:0] funct3T;

    // OP and OP-IMM
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Sll    = 3'b001;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Sltu   = 3'b011;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3SrlSra = 3'b101;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    // BRANCH
    localparam funct3T f3Beq  = 3'b000;
    localparam funct3T f3Bne  = 3'b001;
    localparam funct3T f3Blt  = 3'b100;
    localparam funct3T f3Bge  = 3'b101;
    localparam funct3T f3Bltu = 3'b110;
    localparam funct3T f3Bgeu = 3'b111;

endpackage

// ==== execUnit.f ====
+incdir+design
design/rvIsaPkg.sv
design/execPkg.sv
design/execControl.sv
design/immGen.sv
design/aluCore.sv
design/branchUnit.sv
design/regFile.sv
design/execUnit.sv
bench/execUnit_checker.sv
bench/execUnit_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module execUnit_tb -f execUnit.f -o execUnitSim \
    && ./obj_dir/execUnitSim | tee /dev/stderr | grep -q "Done: no errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
